// ==== flist.f ====
hdl/uart_pkg.sv
hdl/uart_baud_gen.sv
hdl/u_xmit.sv
hdl/u_rec.sv
hdl/uart.sv
test/uart_asserts.sv
test/tb_clk_gen.sv
test/tb_uart.sv

// ==== test/tb_uart.sv ====
`default_nettype none

module tb_uart;

  wire        sys_clk;
  wire        sys_rst_l;
  logic       xmit;
  logic [7:0] xmit_data;
  logic       loopback;
  logic       rec_drv;
  wire        uart_rec;
  wire        uart_xmit;
  wire        xmit_busy;
  wire        xmit_done;
  wire  [7:0] rec_data;
  wire        rec_ready;
  wire        frame_err;

  int         ready_cnt = 0;
  int         ferr_cnt = 0;
  logic [7:0] last_rx = 8'h00;
  int         seed = 63;

  tb_clk_gen i_clk_gen (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l)
  );

  assign uart_rec = loopback ? uart_xmit : rec_drv;

  uart i_dut (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .uart_xmit (uart_xmit),
    .xmit_busy (xmit_busy),
    .xmit_done (xmit_done),
    .uart_rec  (uart_rec),
    .rec_data  (rec_data),
    .rec_ready (rec_ready),
    .frame_err (frame_err)
  );

  // Receiver pulse counters.
  always @(posedge sys_clk) begin
    if (rec_ready) begin
      ready_cnt <= ready_cnt + 1;
      last_rx   <= rec_data;
    end
    if (frame_err) begin
      ferr_cnt <= ferr_cnt + 1;
    end
  end

  always @(posedge sys_clk) begin
    if (i_dut.i_xmit.i_asserts.fail_cnt != 0) begin
      $display("error at %0t: transmitter assertion failed", $time);
      stop_with_fail();
    end
  end

  task automatic stop_with_fail();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      stop_with_fail();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("error at %0t: timed out waiting for %s", $time, what);
    stop_with_fail();
  endtask

  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (xmit_busy) begin
      if (n == 1000) timeout_fail("transmitter idle");
      next_cycle();
      n++;
    end
  endtask

  // Returns once the receiver event count moves past events.
  task automatic wait_rx(input int events);
    int n;
    n = 0;
    while (ready_cnt + ferr_cnt == events) begin
      if (n == 800) timeout_fail("rec_ready or frame_err");
      next_cycle();
      n++;
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    wait_tx_idle();
    xmit      = 1'b1;
    xmit_data = b;
    next_cycle();
    xmit      = 1'b0;
  endtask

  task automatic loop_byte(input logic [7:0] b);
    int rb;
    int eb;
    rb = ready_cnt;
    eb = ferr_cnt;
    send_byte(b);
    wait_rx(rb + eb);
    compare_val("frame_err count", ferr_cnt, eb);
    compare_val("rec_data", last_rx, b);
  endtask

  task automatic expect_line_idle(input int cycles);
    wait_tx_idle();
    repeat (cycles) begin
      compare_val("uart_xmit", uart_xmit, 1'b1);
      compare_val("xmit_busy", xmit_busy, 1'b0);
      next_cycle();
    end
  endtask

  task automatic drive_serial(input logic [7:0] d, input logic stop);
    logic [9:0] frame;
    frame = {stop, d, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rec_drv = frame[i];
      repeat (64) next_cycle();
    end
    rec_drv = 1'b1;
  endtask

  task automatic reset_values();
    int n;
    n = 0;
    while (sys_rst_l !== 1'b1) begin
      if (n == 20) timeout_fail("reset release");
      next_cycle();
      n++;
    end
    compare_val("uart_xmit", uart_xmit, 1'b1);
    compare_val("xmit_done", xmit_done, 1'b0);
    compare_val("xmit_busy", xmit_busy, 1'b0);
    compare_val("rec_ready", rec_ready, 1'b0);
    compare_val("frame_err", frame_err, 1'b0);
    compare_val("rec_data", rec_data, 8'h00);
  endtask

  task automatic fixed_loopback();
    logic [7:0] bytes [10] = '{8'h00, 8'hFF, 8'h55, 8'hAA, 8'h11,
                               8'hAA, 8'h00, 8'h55, 8'hFF, 8'hA5};
    int rb;
    rb = ready_cnt;
    foreach (bytes[i]) begin
      loop_byte(bytes[i]);
    end
    expect_line_idle(128);
    compare_val("frames received", ready_cnt - rb, 10);
  endtask

  task automatic random_loopback();
    logic [7:0] b;
    repeat (20) begin
      b = $random(seed);
      loop_byte(b);
    end
  endtask

  task automatic frame_shape(input logic [7:0] b);
    int n;
    int base;
    base = ready_cnt + ferr_cnt;
    send_byte(b);
    n = 0;
    while (uart_xmit) begin
      if (n == 100) timeout_fail("start bit");
      next_cycle();
      n++;
    end
    repeat (32) next_cycle();
    compare_val("start bit", uart_xmit, 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (64) next_cycle();
      compare_val($sformatf("data bit %0d", i), uart_xmit, b[i]);
    end
    repeat (64) next_cycle();
    compare_val("stop bit", uart_xmit, 1'b1);
    n = 0;
    while (!xmit_done) begin
      if (n == 70) timeout_fail("xmit_done after stop bit");
      next_cycle();
      n++;
    end
    wait_rx(base);
    compare_val("rec_data", last_rx, b);
  endtask

  // Prev is the last byte that reached the receiver.
  task automatic framing_error(input logic [7:0] prev);
    int rb;
    int eb;
    wait_tx_idle();
    loopback = 1'b0;
    rb = ready_cnt;
    eb = ferr_cnt;
    drive_serial(~prev, 1'b0);
    wait_rx(rb + eb);
    compare_val("frame_err count", ferr_cnt, eb + 1);
    compare_val("rec_ready count", ready_cnt, rb);
    compare_val("rec_data", rec_data, prev);
    // A low stop bit may read as a new start; let that frame run out.
    repeat (12 * 64) next_cycle();
    loopback = 1'b1;
  endtask

  task automatic busy_ignore();
    int rb;
    int n;
    rb = ready_cnt;
    send_byte(8'hC3);
    n = 0;
    while (!xmit_done) begin
      if (n == 800) timeout_fail("xmit_done");
      compare_val("xmit_busy", xmit_busy, 1'b1);
      if (n == 200) begin
        xmit_data = 8'h3C;
      end
      xmit = (n == 200);
      next_cycle();
      n++;
    end
    xmit = 1'b0;
    expect_line_idle(11 * 64);
    compare_val("frames received", ready_cnt - rb, 1);
    compare_val("rec_data", last_rx, 8'hC3);
  endtask

  initial begin
    xmit      = 1'b0;
    xmit_data = 8'h00;
    loopback  = 1'b1;
    rec_drv   = 1'b1;
    reset_values();
    fixed_loopback();
    random_loopback();
    frame_shape(8'h4B);
    framing_error(8'h4B);
    busy_ignore();
    if (i_dut.i_xmit.i_asserts.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic sys_clk,
  output logic sys_rst_l
);

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  // Reset held low for two clock cycles.
  initial begin
    sys_rst_l = 1'b0;
    repeat (2) @(posedge sys_clk);
    #1;
    sys_rst_l = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/uart_asserts.sv ====
`default_nettype none

module uart_asserts (
  input wire                                       sys_clk,
  input wire                                       sys_rst_l,
  input wire [$bits(uart_pkg::xmit_state_t)-1:0]   state,
  input wire                                       xmit,
  input wire                                       uart_xmit,
  input wire                                       xmit_done
);

  int fail_cnt = 0;

  // Idle line stays at the mark level.
  idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    state == uart_pkg::x_idle |-> uart_xmit)
    else begin
      fail_cnt++;
      $error("uart_xmit low while transmitter idle");
    end

  done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    xmit_done |=> !xmit_done)
    else begin
      fail_cnt++;
      $error("xmit_done longer than one cycle");
    end

  // Start bit begins right after acceptance.
  start_low: assert property (@(posedge sys_clk) disable iff (!sys_rst_l)
    state == uart_pkg::x_idle && xmit |=> !uart_xmit)
    else begin
      fail_cnt++;
      $error("uart_xmit not low after acceptance");
    end

endmodule

bind u_xmit uart_asserts i_asserts (
  .sys_clk   (sys_clk),
  .sys_rst_l (sys_rst_l),
  .state     (state),
  .xmit      (xmit),
  .uart_xmit (uart_xmit),
  .xmit_done (xmit_done)
);

`default_nettype wire

// ==== hdl/uart.sv ====
`default_nettype none

module uart (
  input  wire        sys_clk,
  input  wire        sys_rst_l,
  input  wire        xmit,
  input  wire  [7:0] xmit_data,
  output wire        uart_xmit,
  output wire        xmit_busy,
  output wire        xmit_done,
  input  wire        uart_rec,
  output wire  [7:0] rec_data,
  output wire        rec_ready,
  output wire        frame_err
);

  wire baud_tick;

  // Shared 16x tick.
  uart_baud_gen i_baud_gen (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick)
  );

  u_xmit i_xmit (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick),
    .xmit      (xmit),
    .xmit_data (xmit_data),
    .uart_xmit (uart_xmit),
    .xmit_busy (xmit_busy),
    .xmit_done (xmit_done)
  );

  u_rec i_rec (
    .sys_clk   (sys_clk),
    .sys_rst_l (sys_rst_l),
    .baud_tick (baud_tick),
    .uart_rec  (uart_rec),
    .rec_data  (rec_data),
    .rec_ready (rec_ready),
    .frame_err (frame_err)
  );

endmodule

`default_nettype wire

// ==== hdl/u_rec.sv ====
`default_nettype none

module u_rec (
  input  wire        sys_clk,
  input  wire        sys_rst_l,
  input  wire        baud_tick,
  input  wire        uart_rec,
  output logic [7:0] rec_data,
  output logic       rec_ready,
  output logic       frame_err
);

  uart_pkg::rec_state_t state;
  uart_pkg::rec_state_t next_state;

  logic rx_meta;
  logic rx_s;

  logic [uart_pkg::tick_cnt_w-1:0] tick_cnt;
  logic [uart_pkg::bit_cnt_w-1:0]  bit_cnt;
  logic [7:0]                      shift_reg;

  logic cell_end;
  logic start_mid;
  logic last_bit;
  logic cnt_clr;
  logic shift_in;
  logic bit_ena;
  logic ready_in;
  logic err_in;

  // Two-flop synchronizer; idles high like the line.
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= uart_rec;
      rx_s    <= rx_meta;
    end
  end

  assign cell_end  = baud_tick &&
                     (tick_cnt == uart_pkg::tick_cnt_w'(uart_pkg::ticks_per_bit - 1));
  assign start_mid = baud_tick &&
                     (tick_cnt == uart_pkg::tick_cnt_w'(uart_pkg::ticks_per_bit / 2 - 1));
  assign last_bit  = (bit_cnt == uart_pkg::bit_cnt_w'(uart_pkg::word_len - 1));

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state <= uart_pkg::r_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cnt_clr    = 1'b0;
    shift_in   = 1'b0;
    bit_ena    = 1'b0;
    ready_in   = 1'b0;
    err_in     = 1'b0;
    case (state)
      uart_pkg::r_idle: begin
        cnt_clr = 1'b1;
        if (!rx_s) begin
          next_state = uart_pkg::r_start;
        end
      end
      uart_pkg::r_start: begin
        // Line back high before mid-bit is a glitch.
        if (baud_tick && rx_s) begin
          next_state = uart_pkg::r_idle;
        end else if (start_mid) begin
          next_state = uart_pkg::r_data;
          cnt_clr    = 1'b1;
        end
      end
      uart_pkg::r_data: begin
        if (cell_end) begin
          shift_in = 1'b1;
          if (last_bit) begin
            next_state = uart_pkg::r_stop;
          end else begin
            bit_ena = 1'b1;
          end
        end
      end
      uart_pkg::r_stop: begin
        if (cell_end) begin
          next_state = uart_pkg::r_idle;
          ready_in   = rx_s;
          err_in     = !rx_s;
        end
      end
      default: begin
        next_state = uart_pkg::r_idle;
      end
    endcase
  end

  // Tick counter keeps samples at mid-bit.
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      tick_cnt <= '0;
    end else if (cnt_clr || cell_end) begin
      tick_cnt <= '0;
    end else if (baud_tick) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (state == uart_pkg::r_idle) begin
      bit_cnt <= '0;
    end else if (bit_ena) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // First bit ends up in bit 0.
  always_ff @(posedge sys_clk) begin
    if (shift_in) begin
      shift_reg <= {rx_s, shift_reg[7:1]};
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      rec_data  <= '0;
      rec_ready <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rec_ready <= ready_in;
      frame_err <= err_in;
      if (ready_in) begin
        rec_data <= shift_reg;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/u_xmit.sv ====
`default_nettype none

module u_xmit (
  input  wire        sys_clk,
  input  wire        sys_rst_l,
  input  wire        baud_tick,
  input  wire        xmit,
  input  wire  [7:0] xmit_data,
  output logic       uart_xmit,
  output logic       xmit_busy,
  output logic       xmit_done
);

  uart_pkg::xmit_state_t state;
  uart_pkg::xmit_state_t next_state;

  logic [uart_pkg::tick_cnt_w-1:0] tick_cnt;
  logic [uart_pkg::bit_cnt_w-1:0]  bit_cnt;
  logic [7:0]                      shift_reg;

  logic cell_end;
  logic last_bit;
  logic cnt_clr;
  logic load_shift;
  logic shift_ena;
  logic bit_ena;
  logic done_in;

  assign cell_end = baud_tick &&
                    (tick_cnt == uart_pkg::tick_cnt_w'(uart_pkg::ticks_per_bit - 1));
  assign last_bit = (bit_cnt == uart_pkg::bit_cnt_w'(uart_pkg::word_len - 1));

  assign xmit_busy = (state != uart_pkg::x_idle);

  // Line level follows the state.
  always_comb begin
    case (state)
      uart_pkg::x_start: uart_xmit = 1'b0;
      uart_pkg::x_data:  uart_xmit = shift_reg[0];
      default:           uart_xmit = 1'b1;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      state <= uart_pkg::x_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    cnt_clr    = 1'b0;
    load_shift = 1'b0;
    shift_ena  = 1'b0;
    bit_ena    = 1'b0;
    done_in    = 1'b0;
    case (state)
      uart_pkg::x_idle: begin
        cnt_clr = 1'b1;
        // Requests are taken only here.
        if (xmit) begin
          next_state = uart_pkg::x_start;
          load_shift = 1'b1;
        end
      end
      uart_pkg::x_start: begin
        if (cell_end) begin
          next_state = uart_pkg::x_data;
        end
      end
      uart_pkg::x_data: begin
        if (cell_end) begin
          if (last_bit) begin
            next_state = uart_pkg::x_stop;
          end else begin
            shift_ena = 1'b1;
            bit_ena   = 1'b1;
          end
        end
      end
      uart_pkg::x_stop: begin
        if (cell_end) begin
          next_state = uart_pkg::x_idle;
          done_in    = 1'b1;
        end
      end
      default: begin
        next_state = uart_pkg::x_idle;
      end
    endcase
  end

  // Bit-cell counter, advanced by baud ticks.
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      tick_cnt <= '0;
    end else if (cnt_clr || cell_end) begin
      tick_cnt <= '0;
    end else if (baud_tick) begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      bit_cnt <= '0;
    end else if (cnt_clr) begin
      bit_cnt <= '0;
    end else if (bit_ena) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // LSB goes out first.
  always_ff @(posedge sys_clk) begin
    if (load_shift) begin
      shift_reg <= xmit_data;
    end else if (shift_ena) begin
      shift_reg <= {1'b1, shift_reg[7:1]};
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      xmit_done <= 1'b0;
    end else begin
      xmit_done <= done_in;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_baud_gen.sv ====
`default_nettype none

module uart_baud_gen (
  input  wire  sys_clk,
  input  wire  sys_rst_l,
  output logic baud_tick
);

  logic [uart_pkg::baud_cnt_w-1:0] div_cnt;
  logic                            div_wrap;

  assign div_wrap = (div_cnt == uart_pkg::baud_cnt_w'(uart_pkg::clks_per_tick - 1));

  // Free-running divider.
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      div_cnt <= '0;
    end else if (div_wrap) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // One-cycle tick on each wrap.
  always_ff @(posedge sys_clk or negedge sys_rst_l) begin
    if (!sys_rst_l) begin
      baud_tick <= 1'b0;
    end else begin
      baud_tick <= div_wrap;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // System clocks per baud tick.
  localparam int unsigned clks_per_tick = 4;

  // Baud ticks per bit cell.
  localparam int unsigned ticks_per_bit = 16;

  // Data bits per frame.
  localparam int unsigned word_len = 8;

  // Counter widths derived from the timing above.
  localparam int unsigned baud_cnt_w = $clog2(clks_per_tick);
  localparam int unsigned tick_cnt_w = $clog2(ticks_per_bit);
  localparam int unsigned bit_cnt_w  = $clog2(word_len);

  // Transmitter states.
  typedef enum logic [1:0] {
    x_idle,
    x_start,
    x_data,
    x_stop
  } xmit_state_t;

  // Receiver states.
  typedef enum logic [1:0] {
    r_idle,
    r_start,
    r_data,
    r_stop
  } rec_state_t;

endpackage

`default_nettype wire
